// ==== compile.f ====
design/lanzonesPkg.sv
design/memReqIf.sv
design/memBusCtrl.sv
design/instrDecoder.sv
design/regFile.sv
design/coreSequencer.sv
design/lanzones.sv
testbench/memModel.sv
testbench/lanzonesTb.sv

// ==== design/coreSequencer.sv ====
`timescale 1ns/1ps

module coreSequencer (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  LEn,
   output logic                  Halt,
   memReqIf.core                 bus,
   output lanzonesPkg::word_t    instr,
   input  lanzonesPkg::opClass_t opClass,
   input  lanzonesPkg::regIdx_t  rd,
   input  lanzonesPkg::regIdx_t  rs1,
   input  lanzonesPkg::regIdx_t  rs2,
   input  lanzonesPkg::word_t    imm,
   output lanzonesPkg::regIdx_t  rdIdxA,
   output lanzonesPkg::regIdx_t  rdIdxB,
   input  lanzonesPkg::word_t    rdDataA,
   input  lanzonesPkg::word_t    rdDataB,
   output logic                  wrEn,
   output lanzonesPkg::regIdx_t  wrIdx,
   output lanzonesPkg::word_t    wrData
);
   import lanzonesPkg::*;

   seqState_t state;
   word_t     pc;
   word_t     nextPc;
   word_t     sum;      // ADD result
   word_t     memAddr;  // load/store address
   logic      fetchNext;

   assign rdIdxA  = rs1;
   assign rdIdxB  = rs2;
   assign nextPc  = pc + 32'd1;
   assign sum     = rdDataA + rdDataB;
   assign memAddr = rdDataA + imm;

   // instruction finished without a data access, or data access answered
   assign fetchNext = ((state == stExec) && !(opClass inside {opStore, opLoad, opHalt}))
                      || ((state == stMem) && bus.done);

   assign wrIdx = rd;

   always_comb begin
      wrEn   = 1'b0;
      wrData = imm;
      case (state)
         stExec: begin
            wrEn   = (opClass == opLui) || (opClass == opAdd);
            wrData = (opClass == opAdd) ? sum : imm;
         end
         stMem: begin
            wrEn   = bus.done && (opClass == opLoad);  // load data lands in the done cycle
            wrData = bus.rdata;
         end
         default: begin
            wrEn = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= stIdle;
         Halt      <= 1'b1;
         pc        <= '0;
         bus.req   <= 1'b0;
         bus.addr  <= '0;
         bus.write <= 1'b0;
         bus.wdata <= '0;
      end else begin
         bus.req <= 1'b0;
         if (fetchNext) begin
            pc        <= nextPc;
            bus.req   <= 1'b1;
            bus.addr  <= nextPc;
            bus.write <= 1'b0;
            state     <= stFetch;
         end else begin
            case (state)
               stIdle: begin
                  if (LEn) begin  // restart from word 0
                     Halt      <= 1'b0;
                     pc        <= '0;
                     bus.req   <= 1'b1;
                     bus.addr  <= '0;
                     bus.write <= 1'b0;
                     state     <= stFetch;
                  end
               end
               stFetch: begin
                  if (bus.done) begin
                     state <= stExec;
                  end
               end
               stExec: begin
                  if (opClass == opHalt) begin
                     Halt  <= 1'b1;
                     state <= stIdle;
                  end else begin
                     // only SW and LW get here
                     bus.req   <= 1'b1;
                     bus.addr  <= memAddr;
                     bus.write <= (opClass == opStore);
                     bus.wdata <= rdDataB;
                     state     <= stMem;
                  end
               end
               default: begin
                  state <= stMem;  // waiting on data
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if ((state == stFetch) && bus.done) begin
         instr <= bus.rdata;
      end
   end

   assert property (@(posedge clk) disable iff (!rstn) Halt |-> !bus.req);

endmodule

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder #(
   parameter int numRegs = 32
) (
   input  lanzonesPkg::word_t    instr,
   output lanzonesPkg::opClass_t opClass,
   output lanzonesPkg::regIdx_t  rd,
   output lanzonesPkg::regIdx_t  rs1,
   output lanzonesPkg::regIdx_t  rs2,
   output lanzonesPkg::word_t    imm
);
   import lanzonesPkg::*;

   logic [opcodeWidth-1:0] opcode;

   // registers that do not exist fold onto x0
   function automatic regIdx_t fieldIdx(input word_t w, input int lsb);
      regIdx_t idx;
      idx = w[lsb +: regIdxWidth];
      return (int'(idx) < numRegs) ? idx : '0;
   endfunction

   assign opcode = instr[opcodeWidth-1:0];

   assign rd  = fieldIdx(instr, rdLsb);
   assign rs1 = fieldIdx(instr, rs1Lsb);
   assign rs2 = fieldIdx(instr, rs2Lsb);

   always_comb begin
      case (opcode)
         opcLui:   opClass = opLui;
         opcAdd:   opClass = opAdd;
         opcStore: opClass = opStore;
         opcLoad:  opClass = opLoad;
         opcHalt:  opClass = opHalt;
         default:  opClass = opOther;
      endcase
   end

   always_comb begin
      case (opClass)
         opLui: begin
            imm = {instr[31:12], 12'b0};
         end
         opStore: begin
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S-type split field
         end
         opLoad: begin
            imm = {{20{instr[31]}}, instr[31:20]};
         end
         default: begin
            imm = '0;
         end
      endcase
   end

endmodule

// ==== design/lanzones.sv ====
`timescale 1ns/1ps

module lanzones #(
   parameter int numRegs = 32
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               RVld,
   input  lanzonesPkg::word_t RData,
   input  logic               LEn,
   output logic               RRdy,
   output lanzonesPkg::word_t RAddr,
   output logic               RWEn,
   output lanzonesPkg::word_t RWData,
   output logic               Halt
);
   import lanzonesPkg::*;

   memReqIf memBus ();

   word_t    instr;
   opClass_t opClass;
   regIdx_t  rd;
   regIdx_t  rs1;
   regIdx_t  rs2;
   word_t    imm;
   regIdx_t  rdIdxA;
   regIdx_t  rdIdxB;
   word_t    rdDataA;
   word_t    rdDataB;
   logic     wrEn;
   regIdx_t  wrIdx;
   word_t    wrData;

   memBusCtrl uBusCtrl (
      .clk    (clk),
      .rstn   (rstn),
      .bus    (memBus.mem),
      .RVld   (RVld),
      .RData  (RData),
      .RRdy   (RRdy),
      .RAddr  (RAddr),
      .RWEn   (RWEn),
      .RWData (RWData)
   );

   instrDecoder #(
      .numRegs (numRegs)
   ) uDecoder (
      .instr   (instr),
      .opClass (opClass),
      .rd      (rd),
      .rs1     (rs1),
      .rs2     (rs2),
      .imm     (imm)
   );

   regFile #(
      .numRegs (numRegs)
   ) uRegFile (
      .clk     (clk),
      .rstn    (rstn),
      .rdIdxA  (rdIdxA),
      .rdIdxB  (rdIdxB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wrEn),
      .wrIdx   (wrIdx),
      .wrData  (wrData)
   );

   coreSequencer uSequencer (
      .clk     (clk),
      .rstn    (rstn),
      .LEn     (LEn),
      .Halt    (Halt),
      .bus     (memBus.core),
      .instr   (instr),
      .opClass (opClass),
      .rd      (rd),
      .rs1     (rs1),
      .rs2     (rs2),
      .imm     (imm),
      .rdIdxA  (rdIdxA),
      .rdIdxB  (rdIdxB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wrEn),
      .wrIdx   (wrIdx),
      .wrData  (wrData)
   );

endmodule

// ==== design/lanzonesPkg.sv ====
package lanzonesPkg;

   localparam int xlen        = 32;
   localparam int regIdxWidth = 5;
   localparam int opcodeWidth = 7;

   typedef logic [xlen-1:0]        word_t;
   typedef logic [regIdxWidth-1:0] regIdx_t;

   // instruction field positions
   localparam int rdLsb  = 7;
   localparam int rs1Lsb = 15;
   localparam int rs2Lsb = 20;

   localparam logic [opcodeWidth-1:0] opcLui   = 7'b0110111;
   localparam logic [opcodeWidth-1:0] opcAdd   = 7'b0110011;
   localparam logic [opcodeWidth-1:0] opcStore = 7'b0100011;
   localparam logic [opcodeWidth-1:0] opcLoad  = 7'b0000011;
   localparam logic [opcodeWidth-1:0] opcHalt  = 7'b1111111;

   typedef enum logic [2:0] {
      opLui,
      opAdd,
      opStore,
      opLoad,
      opHalt,
      opOther  // anything unrecognised, treated as a no-op
   } opClass_t;

   typedef enum logic [1:0] {
      stIdle,  // halted
      stFetch,
      stExec,
      stMem
   } seqState_t;

endpackage

// ==== design/memBusCtrl.sv ====
`timescale 1ns/1ps

module memBusCtrl (
   input  logic               clk,
   input  logic               rstn,
   memReqIf.mem               bus,
   input  logic               RVld,
   input  lanzonesPkg::word_t RData,
   output logic               RRdy,
   output lanzonesPkg::word_t RAddr,
   output logic               RWEn,
   output lanzonesPkg::word_t RWData
);

   logic respSeen;

   assign respSeen = RRdy && RVld;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         RRdy     <= 1'b0;
         RAddr    <= '0;
         RWEn     <= 1'b0;
         RWData   <= '0;
         bus.done <= 1'b0;
      end else begin
         bus.done <= respSeen;
         if (bus.req) begin
            RRdy   <= 1'b1;
            RAddr  <= bus.addr;
            RWEn   <= bus.write;
            RWData <= bus.wdata;
         end else if (respSeen) begin
            RRdy <= 1'b0;  // low for at least the done cycle
            RWEn <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (respSeen) begin
         bus.rdata <= RData;
      end
   end

   // request held on the port until memory answers
   assert property (@(posedge clk) disable iff (!rstn)
      RRdy && !RVld |=> RRdy && $stable(RAddr) && $stable(RWData) && $stable(RWEn));

   // core never overlaps transactions
   assert property (@(posedge clk) disable iff (!rstn) bus.req |-> !RRdy);

endmodule

// ==== design/memReqIf.sv ====
`timescale 1ns/1ps

interface memReqIf;
   import lanzonesPkg::*;

   logic  req;    // one-cycle pulse from the core
   word_t addr;
   logic  write;
   word_t wdata;
   logic  done;   // one-cycle pulse back to the core
   word_t rdata;

   modport core (
      output req, addr, write, wdata,
      input  done, rdata
   );

   modport mem (
      input  req, addr, write, wdata,
      output done, rdata
   );

endinterface

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
   parameter int numRegs = 32
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  lanzonesPkg::regIdx_t rdIdxA,
   input  lanzonesPkg::regIdx_t rdIdxB,
   output lanzonesPkg::word_t   rdDataA,
   output lanzonesPkg::word_t   rdDataB,
   input  logic                 wrEn,
   input  lanzonesPkg::regIdx_t wrIdx,
   input  lanzonesPkg::word_t   wrData
);
   import lanzonesPkg::*;

   word_t regs [numRegs];
   logic  wrOk;

   // x0 and absent entries are never written
   assign wrOk = wrEn && (wrIdx != '0) && (int'(wrIdx) < numRegs);

   assign rdDataA = (int'(rdIdxA) < numRegs) ? regs[rdIdxA] : '0;
   assign rdDataB = (int'(rdIdxB) < numRegs) ? regs[rdIdxB] : '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrOk) begin
         regs[wrIdx] <= wrData;
      end
   end

   // x0 reads zero on both ports
   assert property (@(posedge clk) disable iff (!rstn)
      (rdIdxA != '0 || rdDataA == '0) && (rdIdxB != '0 || rdDataB == '0));

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f compile.f --top-module lanzonesTb -o lanzonesSim

./obj_dir/lanzonesSim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
   exit 0
fi
exit 1

// ==== testbench/lanzonesTb.sv ====
`timescale 1ns/1ps

module lanzonesTb;
   import lanzonesPkg::*;

   localparam int          seedStart = 32'hb661;
   localparam int          progLen   = 20;
   localparam int          numProgs  = 3;
   localparam logic [11:0] dataBase  = 12'h800;  // 8-word data region

   logic        clk;
   logic        rstn;
   logic        RVld;
   word_t       RData;
   logic        LEn;
   logic        RRdy;
   word_t       RAddr;
   logic        RWEn;
   word_t       RWData;
   logic        Halt;
   logic        loadEn;
   logic [11:0] loadAddr;
   word_t       loadData;

   integer seed = seedStart;
   int     errors = 0;
   int     checks = 0;
   word_t  refRegs [32];  // only x0..x7 are used
   word_t  refData [8];
   word_t  prog [progLen+1];
   word_t  expAddr [$];
   logic   expWrite [$];
   word_t  expWData [$];

   lanzones #(.numRegs(32)) u_lanzones (.*);
   memModel #(.seedInit(seedStart)) uMem (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic checkWord(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic expectTxn(input word_t addr, input logic write, input word_t data);
      expAddr.push_back(addr);
      expWrite.push_back(write);
      expWData.push_back(data);
   endtask

   task automatic loadWord(input logic [11:0] addr, input word_t data);
      loadEn   = 1'b1;
      loadAddr = addr;
      loadData = data;
      @(posedge clk);
      #1;
   endtask

   // executes each instruction as it is generated and queues the bus traffic it implies
   task automatic buildProgram();
      int          kind;
      regIdx_t     rd;
      regIdx_t     rs1;
      regIdx_t     rs2;
      logic [19:0] upper;
      logic [11:0] imm;
      word_t       addr;
      for (int pc = 0; pc < progLen; pc++) begin
         kind  = $unsigned($random(seed)) % 4;
         rd    = regIdx_t'($unsigned($random(seed)) % 8);
         rs1   = regIdx_t'($unsigned($random(seed)) % 8);
         rs2   = regIdx_t'($unsigned($random(seed)) % 8);
         upper = 20'($random(seed));
         // offset that puts rs1 + imm inside the data region
         imm   = dataBase + 12'($unsigned($random(seed)) % 8) - refRegs[rs1][11:0];
         addr  = refRegs[rs1] + {{20{imm[11]}}, imm};
         expectTxn(word_t'(pc), 1'b0, '0);  // fetch
         case (kind)
            0: begin
               prog[pc] = {upper, rd, 7'b0110111};
               if (rd != 0)
                  refRegs[rd] = {upper, 12'h000};
            end
            1: begin
               prog[pc] = {7'h00, rs2, rs1, 3'h0, rd, 7'b0110011};
               if (rd != 0)
                  refRegs[rd] = refRegs[rs1] + refRegs[rs2];
            end
            2: begin
               prog[pc] = {imm[11:5], rs2, rs1, 3'h2, imm[4:0], 7'b0100011};
               expectTxn(addr, 1'b1, refRegs[rs2]);
               refData[addr[2:0]] = refRegs[rs2];
            end
            default: begin
               prog[pc] = {imm, rs1, 3'h2, rd, 7'b0000011};
               expectTxn(addr, 1'b0, '0);
               if (rd != 0)
                  refRegs[rd] = refData[addr[2:0]];
            end
         endcase
      end
      prog[progLen] = 32'h0000_007f;  // halt
      expectTxn(word_t'(progLen), 1'b0, '0);
   endtask

   task automatic watchTransactions();
      word_t a;
      logic  w;
      word_t d;
      forever begin
         @(negedge clk);  // response cycle is stable here
         if (rstn && RVld) begin
            assert (expAddr.size() > 0) else begin
               errors++;
               $display("unexpected memory transaction at %0t, address %h", $time, RAddr);
            end
            if (expAddr.size() > 0) begin
               a = expAddr.pop_front();
               w = expWrite.pop_front();
               d = expWData.pop_front();
               checkWord("RAddr", RAddr, a);
               checkWord("RWEn", {31'b0, RWEn}, {31'b0, w});
               if (w)
                  checkWord("RWData", RWData, d);
            end
         end
      end
   endtask

   initial begin
      int n;
      rstn     = 1'b0;
      LEn      = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      refRegs  = '{default: '0};
      fork
         watchTransactions();
      join_none
      repeat (8) @(posedge clk);
      #1;
      rstn = 1'b1;
      repeat (10) begin  // nothing moves before LEn
         @(posedge clk);
         #1;
         assert (Halt === 1'b1 && RRdy === 1'b0) else begin
            errors++;
            $display("core not halted and idle after reset at %0t", $time);
         end
      end
      for (int k = 0; k < 8; k++) begin
         refData[k] = $random(seed);
         loadWord(dataBase + 12'(k), refData[k]);
      end
      // registers and data carry over from one program to the next
      for (int p = 0; p < numProgs; p++) begin
         buildProgram();
         for (int i = 0; i <= progLen; i++)
            loadWord(12'(i), prog[i]);
         loadEn = 1'b0;
         LEn    = 1'b1;
         @(posedge clk);
         #1;
         LEn = 1'b0;
         n   = 0;
         while (Halt !== 1'b1 && n < 2000) begin
            @(posedge clk);
            #1;
            n++;
         end
         if (Halt !== 1'b1) begin
            errors++;
            $display("timeout: program %0d did not halt within 2000 cycles", p);
            break;
         end
         assert (expAddr.size() == 0) else begin
            errors++;
            $display("program %0d halted with %0d transactions missing", p, expAddr.size());
         end
         repeat (50) begin
            @(posedge clk);
            #1;
            assert (Halt === 1'b1 && RRdy === 1'b0) else begin
               errors++;
               $display("memory request or Halt drop after halt at %0t", $time);
            end
         end
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== testbench/memModel.sv ====
`timescale 1ns/1ps

module memModel #(
   parameter int seedInit = 32'hb661
) (
   input  logic               clk,
   input  logic               RRdy,
   input  lanzonesPkg::word_t RAddr,
   input  logic               RWEn,
   input  lanzonesPkg::word_t RWData,
   output logic               RVld,
   output lanzonesPkg::word_t RData,
   input  logic               loadEn,    // preload port, used only while the core is halted
   input  logic [11:0]        loadAddr,
   input  lanzonesPkg::word_t loadData
);
   import lanzonesPkg::*;

   word_t  words [4096];  // addresses alias on RAddr[11:0]
   integer seed;
   int     lat;

   initial begin
      seed  = seedInit;
      RVld  = 1'b0;
      RData = '0;
      for (int i = 0; i < 4096; i++) begin
         words[i] = {~i[11:0], 8'h5a, i[11:0]};
      end
      forever begin
         @(posedge clk);
         if (loadEn) begin
            words[loadAddr] = loadData;
         end
         #1;
         if (RRdy === 1'b1) begin
            lat = 1 + ($unsigned($random(seed)) % 4);
            repeat (lat - 1) begin
               @(posedge clk);
               #1;
            end
            RVld = 1'b1;
            if (RWEn) begin
               words[RAddr[11:0]] = RWData;
            end else begin
               RData = words[RAddr[11:0]];
            end
            $display("mem %s addr %h data %h", RWEn ? "wr" : "rd", RAddr, RWEn ? RWData : RData);
            @(posedge clk);
            #1;
            RVld = 1'b0;  // single-cycle response
         end
      end
   end

endmodule
